// ==== hdl/dds_pkg.sv ====
package dds_pkg;

	////////////////////////////////////////
	// value and instruction widths
	////////////////////////////////////////

	localparam int freq_w  = 48;  // frequency tuning word
	localparam int phase_w = 14;  // phase offset
	localparam int amp_w   = 10;  // amplitude scale factor
	localparam int instr_w = 64;  // longest instruction, short ones left-aligned
	localparam int len_w   = 7;   // holds a bit count up to 64
	localparam int hdr_w   = 16;  // instruction header width

	////////////////////////////////////////
	// instruction headers
	////////////////////////////////////////

	// write bit, byte count field, register address
	localparam logic [hdr_w-1:0] freq_hdr  = {1'b0, 2'b11, 13'h01ab};  // ftw, 6 bytes
	localparam logic [hdr_w-1:0] phase_hdr = {1'b0, 2'b01, 13'h01ad};  // phase, 2 bytes
	localparam logic [hdr_w-1:0] amp_hdr   = {1'b0, 2'b01, 13'h040c};  // dac fsc, 2 bytes

	// frame lengths in bits, header included
	localparam logic [len_w-1:0] freq_len  = 7'd64;
	localparam logic [len_w-1:0] phase_len = 7'd32;
	localparam logic [len_w-1:0] amp_len   = 7'd32;

	////////////////////////////////////////
	// channel codes
	////////////////////////////////////////

	typedef enum logic [1:0] {
		chan_freq  = 2'd0,  // highest priority
		chan_phase = 2'd1,
		chan_amp   = 2'd2   // lowest priority
	} chan_t;

endpackage

// ==== hdl/dds_update_arbiter.sv ====
`timescale 1ns/1ps

module dds_update_arbiter #(
	parameter int queue_depth = 2  // engine queue depth, starting credits
) (
	input  logic                         clk_in,
	input  logic                         reset_in,
	input  logic [dds_pkg::freq_w-1:0]   freq_data,
	input  logic                         freq_valid,
	input  logic [dds_pkg::phase_w-1:0]  phase_data,
	input  logic                         phase_valid,
	input  logic [dds_pkg::amp_w-1:0]    amp_data,
	input  logic                         amp_valid,
	input  logic                         credit_return,  // engine popped one instruction
	output logic                         instr_valid,
	output logic [dds_pkg::instr_w-1:0]  instr_data,
	output logic [dds_pkg::len_w-1:0]    instr_len
);

localparam int credit_w = $clog2(queue_depth + 1);  // counts 0..queue_depth

////////////////////////////////////////
// pending state
////////////////////////////////////////

logic [dds_pkg::freq_w-1:0]  freq_val;   // latest frequency word
logic [dds_pkg::phase_w-1:0] phase_val;  // latest phase offset
logic [dds_pkg::amp_w-1:0]   amp_val;    // latest amplitude
logic                        freq_pend;  // value not yet sent
logic                        phase_pend;
logic                        amp_pend;
logic [credit_w-1:0]         credits;    // free slots in engine queue
dds_pkg::chan_t              sel;        // channel picked this cycle
logic                        issue;      // instruction leaves this cycle

// newest value always wins
always_ff @(posedge clk_in) begin
	if (freq_valid) begin
		freq_val <= freq_data;
	end
	if (phase_valid) begin
		phase_val <= phase_data;
	end
	if (amp_valid) begin
		amp_val <= amp_data;
	end
end

// a strobe in the issue cycle re-arms the flag
always_ff @(posedge clk_in) begin
	if (reset_in) begin
		freq_pend  <= 1'b0;
		phase_pend <= 1'b0;
		amp_pend   <= 1'b0;
	end else begin
		if (freq_valid) begin
			freq_pend <= 1'b1;
		end else if (issue && sel == dds_pkg::chan_freq) begin
			freq_pend <= 1'b0;
		end
		if (phase_valid) begin
			phase_pend <= 1'b1;
		end else if (issue && sel == dds_pkg::chan_phase) begin
			phase_pend <= 1'b0;
		end
		if (amp_valid) begin
			amp_pend <= 1'b1;
		end else if (issue && sel == dds_pkg::chan_amp) begin
			amp_pend <= 1'b0;
		end
	end
end

////////////////////////////////////////
// priority pick and instruction build
////////////////////////////////////////

assign issue       = (credits != '0) && (freq_pend || phase_pend || amp_pend);
assign instr_valid = issue;  // one cycle per instruction

// fixed order freq > phase > amp
always_comb begin
	if (freq_pend) begin
		sel = dds_pkg::chan_freq;
	end else if (phase_pend) begin
		sel = dds_pkg::chan_phase;
	end else begin
		sel = dds_pkg::chan_amp;
	end
end

// header then zero-extended value, msb aligned
always_comb begin
	case (sel)
		dds_pkg::chan_freq: begin
			instr_data = {dds_pkg::freq_hdr, freq_val};  // fills all 64 bits
			instr_len  = dds_pkg::freq_len;
		end
		dds_pkg::chan_phase: begin
			instr_data = {dds_pkg::phase_hdr,
				(dds_pkg::phase_len - dds_pkg::hdr_w)'(phase_val),
				{(dds_pkg::instr_w - dds_pkg::phase_len){1'b0}}};
			instr_len  = dds_pkg::phase_len;
		end
		default: begin
			instr_data = {dds_pkg::amp_hdr,
				(dds_pkg::amp_len - dds_pkg::hdr_w)'(amp_val),
				{(dds_pkg::instr_w - dds_pkg::amp_len){1'b0}}};
			instr_len  = dds_pkg::amp_len;
		end
	endcase
end

////////////////////////////////////////
// credit counter
////////////////////////////////////////

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		credits <= credit_w'(queue_depth);  // engine queue starts empty
	end else begin
		case ({issue, credit_return})
			2'b10:   credits <= credits - 1'b1;
			2'b01:   credits <= credits + 1'b1;
			default: credits <= credits;  // both or neither
		endcase
	end
end

// engine returns no more credits than it was given
a_credit_max: assert property (@(posedge clk_in) disable iff (reset_in)
	credits <= credit_w'(queue_depth));

endmodule

// ==== hdl/dds_serial_engine.sv ====
`timescale 1ns/1ps

module dds_serial_engine #(
	parameter int queue_depth  = 2,  // instruction slots
	parameter int setup_cycles = 2   // quiet clocks before io_update
) (
	input  logic                         clk_in,
	input  logic                         reset_in,
	input  logic                         instr_valid,    // push, never refused
	input  logic [dds_pkg::instr_w-1:0]  instr_data,
	input  logic [dds_pkg::len_w-1:0]    instr_len,
	output logic                         credit_return,  // one pulse per pop
	output logic                         dds_sclk,
	output logic                         dds_csb,
	output logic                         dds_sdio,
	output logic                         dds_io_update,
	output logic                         done
);

localparam int ptr_w  = (queue_depth > 1) ? $clog2(queue_depth) : 1;
localparam int cnt_w  = $clog2(queue_depth + 1);
localparam int wait_w = (setup_cycles > 1) ? $clog2(setup_cycles) : 1;

typedef enum logic [2:0] {
	st_idle,       // queue empty
	st_shift,      // csb low, bits going out
	st_setup,      // csb high, setup time
	st_io_update,  // latch into chip
	st_done        // report end of update
} state_t;

////////////////////////////////////////
// instruction queue
////////////////////////////////////////

logic [dds_pkg::instr_w-1:0] data_q [queue_depth];  // circular buffer
logic [dds_pkg::len_w-1:0]   len_q  [queue_depth];
logic [ptr_w-1:0]            wr_ptr;
logic [ptr_w-1:0]            rd_ptr;
logic [cnt_w-1:0]            count;      // occupied slots
logic                        push;
logic                        pop;        // frame starts next cycle
logic [dds_pkg::instr_w-1:0] head_data;  // next instruction to send
logic [dds_pkg::len_w-1:0]   head_len;
dds_pkg::chan_t              head_chan;  // channel decoded from header

state_t                      state;
logic [dds_pkg::instr_w-1:0] shift_reg;  // msb drives sdio
logic [dds_pkg::len_w-1:0]   bit_cnt;    // bits left in frame
logic                        sclk_phase; // 0 low half, 1 high half
logic [wait_w-1:0]           wait_cnt;

function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
	ptr_next = (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;  // wrap at depth
endfunction

assign push = instr_valid;
assign pop  = (state == st_idle || state == st_done) && (count != '0 || push);

// empty queue hands the incoming word straight through
assign head_data = (count == '0) ? instr_data : data_q[rd_ptr];
assign head_len  = (count == '0) ? instr_len : len_q[rd_ptr];

always_ff @(posedge clk_in) begin
	if (push) begin
		data_q[wr_ptr] <= instr_data;
		len_q[wr_ptr]  <= instr_len;
	end
end

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (push) begin
			wr_ptr <= ptr_next(wr_ptr);
		end
		if (pop) begin
			rd_ptr <= ptr_next(rd_ptr);
		end
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;  // bypass or nothing
		endcase
	end
end

////////////////////////////////////////
// frame state machine
////////////////////////////////////////

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		state         <= st_idle;
		credit_return <= 1'b0;
		bit_cnt       <= '0;
		sclk_phase    <= 1'b0;
		wait_cnt      <= '0;
	end else begin
		credit_return <= pop;  // slot freed in the first frame clock
		case (state)
			st_idle, st_done: begin
				if (pop) begin
					state      <= st_shift;
					bit_cnt    <= head_len;
					sclk_phase <= 1'b0;
				end else begin
					state <= st_idle;
				end
			end
			st_shift: begin
				sclk_phase <= ~sclk_phase;
				if (sclk_phase) begin  // end of bit period
					bit_cnt <= bit_cnt - 1'b1;
					if (bit_cnt == dds_pkg::len_w'(1)) begin
						state    <= st_setup;
						wait_cnt <= '0;
					end
				end
			end
			st_setup: begin
				if (wait_cnt == wait_w'(setup_cycles - 1)) begin
					state <= st_io_update;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
			st_io_update: state <= st_done;
			default:      state <= st_idle;
		endcase
	end
end

// load on pop, shift after the high half
always_ff @(posedge clk_in) begin
	if (pop) begin
		shift_reg <= head_data;
	end else if (state == st_shift && sclk_phase) begin
		shift_reg <= shift_reg << 1;
	end
end

assign dds_csb       = (state != st_shift);
assign dds_sclk      = (state == st_shift) && sclk_phase;  // rises mid bit
assign dds_sdio      = (state == st_shift) && shift_reg[dds_pkg::instr_w-1];
assign dds_io_update = (state == st_io_update);
assign done          = (state == st_done);

////////////////////////////////////////
// checks
////////////////////////////////////////

always_comb begin
	case (head_data[dds_pkg::instr_w-1 -: dds_pkg::hdr_w])
		dds_pkg::freq_hdr:  head_chan = dds_pkg::chan_freq;
		dds_pkg::phase_hdr: head_chan = dds_pkg::chan_phase;
		default:            head_chan = dds_pkg::chan_amp;
	endcase
end

// credits upstream keep the queue from overflowing
a_no_overflow: assert property (@(posedge clk_in) disable iff (reset_in)
	push |-> count < cnt_w'(queue_depth));

// length from the arbiter agrees with the header it built
a_frame_len: assert property (@(posedge clk_in) disable iff (reset_in)
	pop |-> head_len == ((head_chan == dds_pkg::chan_freq)  ? dds_pkg::freq_len :
	                     (head_chan == dds_pkg::chan_phase) ? dds_pkg::phase_len :
	                                                          dds_pkg::amp_len));

endmodule

// ==== hdl/dds_controller.sv ====
`timescale 1ns/1ps

module dds_controller #(
	parameter int queue_depth  = 2,  // power of two, 1 or more
	parameter int setup_cycles = 2   // clocks from csb high to io_update
) (
	input  logic                         clk_in,
	input  logic                         reset_in,
	input  logic [dds_pkg::freq_w-1:0]   freq_data,
	input  logic                         freq_valid,
	input  logic [dds_pkg::phase_w-1:0]  phase_data,
	input  logic                         phase_valid,
	input  logic [dds_pkg::amp_w-1:0]    amp_data,
	input  logic                         amp_valid,
	output logic                         dds_sclk,       // half system clock rate
	output logic                         dds_csb,
	output logic                         dds_sdio,       // msb first
	output logic                         dds_io_update,
	output logic                         dds_reset,
	output logic                         done            // one pulse per update
);

////////////////////////////////////////
// arbiter to engine link
////////////////////////////////////////

logic                        instr_valid;    // costs one credit
logic [dds_pkg::instr_w-1:0] instr_data;     // left-aligned instruction
logic [dds_pkg::len_w-1:0]   instr_len;      // 64 or 32
logic                        credit_return;  // queue slot freed

assign dds_reset = reset_in;  // chip reset tracks system reset

dds_update_arbiter #(
	.queue_depth   (queue_depth)
) i_arbiter (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.freq_data     (freq_data),
	.freq_valid    (freq_valid),
	.phase_data    (phase_data),
	.phase_valid   (phase_valid),
	.amp_data      (amp_data),
	.amp_valid     (amp_valid),
	.credit_return (credit_return),
	.instr_valid   (instr_valid),
	.instr_data    (instr_data),
	.instr_len     (instr_len)
);

dds_serial_engine #(
	.queue_depth   (queue_depth),
	.setup_cycles  (setup_cycles)
) i_engine (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.instr_valid   (instr_valid),
	.instr_data    (instr_data),
	.instr_len     (instr_len),
	.credit_return (credit_return),
	.dds_sclk      (dds_sclk),
	.dds_csb       (dds_csb),
	.dds_sdio      (dds_sdio),
	.dds_io_update (dds_io_update),
	.done          (done)
);

endmodule

// ==== test/tb_dds_controller.sv ====
`timescale 1ns/1ps

module tb_dds_controller;

localparam int queue_depth  = 2;
localparam int setup_cycles = 2;
localparam int clk_period   = 40;
localparam int drive_delay  = 5;                        // after rising edge
localparam int max_lines    = 32;
localparam int frame_clocks = 2 * 64 + setup_cycles + 2;  // longest update

logic        clk_in = 1'b0;
logic        reset_in;
logic [47:0] freq_data;
logic        freq_valid;
logic [13:0] phase_data;
logic        phase_valid;
logic [9:0]  amp_data;
logic        amp_valid;
logic        dds_sclk;
logic        dds_csb;
logic        dds_sdio;
logic        dds_io_update;
logic        dds_reset;
logic        done;

logic [63:0] stim [0:3*max_lines-1];  // chan, value, gap per line
logic [47:0] wr_val [0:2][0:63];      // written values per channel
int          wr_cnt [0:2];
int          rd_idx [0:2];            // oldest value not yet seen on the wire
logic [47:0] last_sent [0:2];
logic [63:0] frame;                   // bits caught from sdio
int          nbits;
int          post_k = -1;             // clocks since csb rose, -1 outside
int          quiet = 0;               // clocks with nothing happening
int          frame_cnt = 0;
int          order_base = -1;         // first frame of an idle triple
int          order_checks = 0;
int          n_lines;
int          limit = 0;
int          seed = 32'h2686;
logic        prev_csb;
logic        prev_sdio;

dds_controller #(
	.queue_depth   (queue_depth),
	.setup_cycles  (setup_cycles)
) i_dut (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.freq_data     (freq_data),
	.freq_valid    (freq_valid),
	.phase_data    (phase_data),
	.phase_valid   (phase_valid),
	.amp_data      (amp_data),
	.amp_valid     (amp_valid),
	.dds_sclk      (dds_sclk),
	.dds_csb       (dds_csb),
	.dds_sdio      (dds_sdio),
	.dds_io_update (dds_io_update),
	.dds_reset     (dds_reset),
	.done          (done)
);

always #(clk_period / 2) clk_in = ~clk_in;

task automatic stop_with_failure(input string why);
	$display("%s", why);
	$display("sim failed");
	$fatal(1, "run stopped");
endtask

// drive one update and log it as expected traffic
task automatic apply_update(input int chan, input logic [47:0] val);
	logic [47:0] kept;
	case (chan)
		0: begin
			freq_data  = val;
			freq_valid = 1'b1;
			kept       = val;
		end
		1: begin
			phase_data  = val[13:0];
			phase_valid = 1'b1;
			kept        = {34'h0, val[13:0]};  // chip sees 14 bits only
		end
		2: begin
			amp_data  = val[9:0];
			amp_valid = 1'b1;
			kept      = {38'h0, val[9:0]};
		end
		default: stop_with_failure("unknown channel code in stimulus file");
	endcase
	wr_val[chan][wr_cnt[chan]] = kept;
	wr_cnt[chan]++;
endtask

// decode a finished frame and match it against the write log
task automatic check_frame();
	logic [15:0] hdr;
	logic [47:0] val;
	int          chan;
	int          exp_len;
	int          j;
	if (nbits == 64) begin
		hdr = frame[63:48];
		val = frame[47:0];
	end else begin
		hdr = frame[31:16];  // short word, header then 16-bit field
		val = {32'h0, frame[15:0]};
	end
	if (hdr == dds_pkg::freq_hdr) chan = 0;
	else if (hdr == dds_pkg::phase_hdr) chan = 1;
	else if (hdr == dds_pkg::amp_hdr) chan = 2;
	else chan = -1;
	assert (chan >= 0)
		else stop_with_failure(
			$sformatf("ERROR dds_sdio header %h matches no channel", hdr));
	exp_len = (chan == 0) ? 64 : 32;
	assert (nbits == exp_len)
		else stop_with_failure(
			$sformatf("ERROR dds_sdio bit count got %h expected %h", nbits, exp_len));
	j = rd_idx[chan];  // skip values that were overwritten
	while (j < wr_cnt[chan] && wr_val[chan][j] != val) j++;
	assert (j < wr_cnt[chan])
		else stop_with_failure(
			$sformatf("ERROR dds_sdio payload %h unwritten or out of order, chan %h",
				val, chan));
	rd_idx[chan]    = j + 1;
	last_sent[chan] = val;
	if (order_base >= 0 && frame_cnt - order_base < 3) begin
		assert (chan == frame_cnt - order_base)
			else stop_with_failure(
				$sformatf("ERROR dds_sdio channel got %h expected %h",
					chan, frame_cnt - order_base));
		order_checks++;
	end
	frame_cnt++;
endtask

////////////////////////////////////////
// serial frame monitor
////////////////////////////////////////

always @(negedge clk_in) begin
	assert (dds_reset === reset_in)
		else stop_with_failure(
			$sformatf("ERROR dds_reset got %h expected %h", dds_reset, reset_in));
	if (reset_in) begin
		prev_csb  = 1'b1;
		prev_sdio = 1'b0;
		post_k    = -1;
		quiet     = 0;
	end else begin
		if (dds_csb === 1'b0) begin
			if (prev_csb) begin  // new frame
				frame = '0;
				nbits = 0;
			end
			assert (post_k < 0 && dds_io_update === 1'b0 && done === 1'b0)
				else stop_with_failure("frame started before the previous update finished");
			quiet = 0;
			if (dds_sclk) begin  // high half, chip samples here
				assert (dds_sdio === prev_sdio)
					else stop_with_failure(
						$sformatf("ERROR dds_sdio got %h expected %h mid bit",
							dds_sdio, prev_sdio));
				frame = {frame[62:0], dds_sdio};
				nbits++;
			end
		end else begin
			if (!prev_csb) begin  // csb just rose
				check_frame();
				post_k = 0;
			end
			assert (dds_sclk === 1'b0 && dds_sdio === 1'b0)
				else stop_with_failure(
					$sformatf("ERROR dds_sclk %h dds_sdio %h expected 0 0",
						dds_sclk, dds_sdio));
			if (post_k >= 0) begin  // setup, io_update, done in turn
				assert (dds_io_update === (post_k == setup_cycles))
					else stop_with_failure(
						$sformatf("ERROR dds_io_update got %h expected %h",
							dds_io_update, post_k == setup_cycles));
				assert (done === (post_k == setup_cycles + 1))
					else stop_with_failure(
						$sformatf("ERROR done got %h expected %h",
							done, post_k == setup_cycles + 1));
				post_k = (post_k == setup_cycles + 1) ? -1 : post_k + 1;
				quiet  = 0;
			end else begin
				assert (dds_io_update === 1'b0 && done === 1'b0)
					else stop_with_failure("io_update or done pulsed without a frame");
				quiet++;
			end
		end
		prev_csb  = dds_csb;
		prev_sdio = dds_sdio;
	end
end

////////////////////////////////////////
// stimulus and final checks
////////////////////////////////////////

initial begin
	int line;
	int gap;
	int max_gap;
	int i;
	reset_in    = 1'b1;
	freq_data   = '0;
	freq_valid  = 1'b0;
	phase_data  = '0;
	phase_valid = 1'b0;
	amp_data    = '0;
	amp_valid   = 1'b0;
	for (i = 0; i < 3; i++) begin
		wr_cnt[i]    = 0;
		rd_idx[i]    = 0;
		last_sent[i] = '1;  // matches no written value
	end
	for (i = 0; i < 3 * max_lines; i++) stim[i] = '1;  // end marker
	$readmemh("test/dds_input.txt", stim);
	n_lines = 0;
	max_gap = 0;
	while (n_lines < max_lines && stim[3*n_lines] <= 64'd2) begin
		if (int'(stim[3*n_lines+2]) > max_gap) max_gap = int'(stim[3*n_lines+2]);
		n_lines++;
	end
	assert (n_lines > 0) else stop_with_failure("stimulus file holds no updates");
	limit = n_lines * (frame_clocks + max_gap + 2) * 2 + 10;  // arms the watchdog

	repeat (3) @(posedge clk_in);
	#drive_delay;
	reset_in = 1'b0;
	@(negedge clk_in);
	assert (dds_csb === 1'b1 && dds_sclk === 1'b0 && dds_sdio === 1'b0 &&
		dds_io_update === 1'b0 && done === 1'b0)
		else stop_with_failure(
			$sformatf("ERROR idle dds_csb %h dds_sclk %h dds_sdio %h dds_io_update %h done %h",
				dds_csb, dds_sclk, dds_sdio, dds_io_update, done));

	line = 0;
	@(posedge clk_in);
	#drive_delay;
	while (line < n_lines) begin
		do begin  // gap 0 groups lines into one clock
			apply_update(int'(stim[3*line]), stim[3*line+1][47:0]);
			gap = int'(stim[3*line+2]);
			line++;
		end while (gap == 0 && line < n_lines);
		if (freq_valid && phase_valid && amp_valid && quiet >= 4) begin
			order_base = frame_cnt;  // idle engine, expect freq phase amp
		end
		if (gap > 0) gap = gap + int'($unsigned($random(seed)) % 3);
		if (gap < 1) gap = 1;
		repeat (gap) begin
			@(posedge clk_in);
			#drive_delay;
			freq_valid  = 1'b0;
			phase_valid = 1'b0;
			amp_valid   = 1'b0;
		end
	end

	repeat (4) @(posedge clk_in);
	wait (quiet >= 8);  // everything drained
	for (i = 0; i < 3; i++) begin
		assert (wr_cnt[i] > 0 && last_sent[i] == wr_val[i][wr_cnt[i]-1])
			else stop_with_failure(
				$sformatf("ERROR dds_sdio last value chan %h got %h expected %h",
					i, last_sent[i], wr_val[i][wr_cnt[i]-1]));
	end
	assert (order_checks >= 3)
		else stop_with_failure(
			"no triple of strobes met an idle engine, priority order unchecked");
	$display("sim passed");
	$finish;
end

// watchdog, limit comes from the stimulus length
initial begin
	wait (limit > 0);
	repeat (limit) @(posedge clk_in);
	stop_with_failure($sformatf("timeout after %0d clocks, updates never finished", limit));
end

endmodule

// ==== build.f ====
hdl/dds_pkg.sv
hdl/dds_update_arbiter.sv
hdl/dds_serial_engine.sv
hdl/dds_controller.sv
test/tb_dds_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dds_controller \
	-f build.f -o tb_dds_controller > sim.log 2>&1 \
	&& ./obj_dir/tb_dds_controller >> sim.log 2>&1 \
	|| echo "sim failed" >> sim.log
grep -q "sim failed" sim.log \
	&& { echo "FAIL, see sim.log"; exit 1; } \
	|| { echo "PASS"; exit 0; }

// ==== test/dds_input.txt ====
// channel (0 freq, 1 phase, 2 amp)   value   clocks to the next update
// all columns hex; a gap of 0 puts the next update in the same clock
0 0123456789ab 0c8
1 0155 0c8
2 02a 0c8
0 111122223333 0
1 1234 0
2 155 190
0 0a0a0a0a0a0a 1
0 0b0b0b0b0b0b 1
1 0001 1
2 001 1
0 0c0c0c0c0c0c 1
1 0002 1
2 002 1
1 0003 2
2 003 2
0 0d0d0d0d0d0d 3
1 0004 1
2 004 40
0 fedcba987654 0
1 3fff 0
2 3ff 190
0 00000000000f 5
1 2000 5
2 200 0c8
